//--- Makefile
# Verilator build and run for the LSU subsystem

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
RTL_TOP   ?= lsu_subsys_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '=== PASS ===' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/ahb_ecc_ram.sv
////////////////////
// Zero-wait AHB-Lite RAM of 39-bit codewords and RAM_WORDS must be a power of two
// Out-of-range or non-word writes get a two-cycle ERROR and are not written
////////////////////
`timescale 1ns/1ps

module ahb_ecc_ram #(
    parameter  int RAM_WORDS = 256,
    localparam int ADDR_W    = ahb_pkg::haddr_w(RAM_WORDS)
) (
    input  logic                       s_clk_i,
    input  logic                       arst_n_i,
    input  logic [ADDR_W-1:0]          haddr_i,
    input  ahb_pkg::htrans_e           htrans_i,
    input  ahb_pkg::hsize_e            hsize_i,
    input  logic                       hwrite_i,
    input  logic [ahb_pkg::DATA_W-1:0] hwdata_i,
    input  logic [ahb_pkg::ECC_W-1:0]  hwcheck_i,
    output logic [ahb_pkg::DATA_W-1:0] hrdata_o,    // Raw, not corrected
    output logic [ahb_pkg::ECC_W-1:0]  hrcheck_o,
    output logic                       hready_o,
    output logic                       hresp_o,
    input  logic [ahb_pkg::CODE_W-1:0] inj_mask_i   // Bits to flip on write
);
    import ahb_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [CODE_W-1:0] mem [RAM_WORDS];
    logic              ap_bad;      // Address phase would fault
    logic              dp_valid;
    logic              dp_write;
    logic              dp_bad;
    logic              err_q;       // Second ERROR cycle
    logic [ADDR_W-3:0] dp_word;     // Word index of the data phase
    logic [CODE_W-1:0] rd_code;

    assign ap_bad = (haddr_i[ADDR_W-1:2] >= (ADDR_W-2)'(RAM_WORDS))
                  | (hwrite_i & (hsize_i != WORD));

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_bad   <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            err_q <= dp_valid & dp_bad & ~err_q;
            if (hready_o) begin
                dp_valid <= (htrans_i == NONSEQ);
                dp_write <= hwrite_i;
                dp_bad   <= ap_bad;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (hready_o) begin
            dp_word <= haddr_i[ADDR_W-1:2];
        end
        // Fault injection hits the whole codeword
        if (dp_valid && dp_write && !dp_bad) begin
            mem[dp_word[IDX_W-1:0]] <= {hwcheck_i, hwdata_i} ^ inj_mask_i;
        end
    end

    assign rd_code   = mem[dp_word[IDX_W-1:0]];
    assign hrdata_o  = rd_code[DATA_W-1:0];
    assign hrcheck_o = rd_code[CODE_W-1:DATA_W];

    // ERROR: hready low then high with hresp held
    assign hready_o = ~(dp_valid & dp_bad & ~err_q);
    assign hresp_o  = dp_valid & dp_bad;

endmodule

//--- design/ahb_pkg.sv
////////////////////
// AHB-Lite subset for single transfers only
// Codeword is 32 data bits plus 7 SECDED check bits
////////////////////
package ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        NONSEQ = 2'b10
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    localparam int DATA_W = 32;             // Bus data width
    localparam int ECC_W  = 7;              // Check bits per word
    localparam int HAM_W  = ECC_W - 1;      // Hamming bits below the overall parity
    localparam int CODE_W = DATA_W + ECC_W; // Stored codeword

    // Byte address width for a RAM of the given depth
    // One spare bit on top lets the core reach addresses the RAM rejects
    function automatic int haddr_w(input int words);
        return $clog2(words) + 3;
    endfunction

    // Hamming position of data bit idx
    // Power-of-two slots belong to the check bits
    function automatic logic [HAM_W-1:0] secded_pos(input int idx);
        int cnt;
        logic [HAM_W-1:0] pos;
        cnt = 0;
        pos = '0;
        for (int p = 3; p < CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = HAM_W'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

//--- design/lsu.sv
////////////////////
// Loads read the aligned word. Sub-word stores run a read-modify-write
// Misaligned LH, LW, SH and SW are not trapped and use the aligned word
// Uncorrectable RMW read data is still merged and written back with einfo set
////////////////////
`timescale 1ns/1ps

module lsu #(
    parameter  int RAM_WORDS = 256,
    localparam int ADDR_W    = ahb_pkg::haddr_w(RAM_WORDS)
) (
    input  logic                            s_clk_i,
    input  logic                            arst_n_i,

    input  logic                            req_valid_i,    // Core request
    input  lsu_pkg::lsu_op_e                req_op_i,
    input  logic [ADDR_W-1:0]               req_addr_i,     // Byte address
    input  logic [ahb_pkg::DATA_W-1:0]      req_wdata_i,    // Store data in low lanes
    output logic                            req_ready_o,

    output logic                            rsp_valid_o,    // One per request, in order
    output logic [ahb_pkg::DATA_W-1:0]      rsp_data_o,     // Load result or zero
    output logic [lsu_pkg::LSU_EINFO_W-1:0] rsp_einfo_o,
    output logic                            rsp_buserr_o,

    output logic [ADDR_W-1:0]               haddr_o,        // AHB master
    output ahb_pkg::htrans_e                htrans_o,
    output ahb_pkg::hsize_e                 hsize_o,
    output logic                            hwrite_o,
    output logic [ahb_pkg::DATA_W-1:0]      hwdata_o,
    output logic [ahb_pkg::ECC_W-1:0]       hwcheck_o,
    input  logic [ahb_pkg::DATA_W-1:0]      hrdata_i,
    input  logic [ahb_pkg::ECC_W-1:0]       hrcheck_i,
    input  logic                            hready_i,
    input  logic                            hresp_i
);
    import lsu_pkg::*;
    import ahb_pkg::*;

    lsu_rmw_e          rmw_q;
    lsu_rmw_e          rmw_d;
    logic              req_sub;     // Sub-word store
    logic              ap_req;      // Accepted request drives the address phase
    logic              ap_rmw;      // Write-back address phase of an RMW
    logic              dp_valid;    // Transfer in data phase
    logic              dp_write;
    logic              dp_done;     // Data phase ends this cycle
    lsu_op_e           dp_op;
    logic [ADDR_W-1:0] dp_addr;
    logic [DATA_W-1:0] dp_wdata;    // Lane-aligned store data or merged word
    logic [DATA_W-1:0] wdata_al;
    logic [DATA_W-1:0] merged;
    logic [3:0]        lane_mask;   // Lanes written by the store
    logic [ECC_W-1:0]  rd_check;
    logic [ECC_W-1:0]  rd_syn;
    logic [ECC_W-1:0]  ld_syn;      // Syndrome of the last read
    logic [DATA_W-1:0] ld_data;     // Raw word of the last read
    logic [DATA_W-1:0] fix_data;
    logic [DATA_W-1:0] lane_data;
    logic              fix_ce;
    logic              fix_uce;
    logic              rs_valid;
    logic              rs_buserr;
    lsu_op_e           rs_op;
    logic [1:0]        rs_off;      // Byte offset for extraction

    assign req_sub     = req_op_i[OP_STORE_BIT] & (req_op_i != SW);
    assign req_ready_o = (rmw_q == RMW_IDLE) & hready_i;  // Stalled by RMW or wait state
    assign ap_req      = req_valid_i & req_ready_o;
    assign ap_rmw      = (rmw_q == RMW_WRITE) & ~dp_valid;
    assign dp_done     = dp_valid & hready_i;

    // Every transfer is a full aligned word
    assign htrans_o = (ap_req | ap_rmw) ? NONSEQ : IDLE;
    assign haddr_o  = ap_rmw ? {dp_addr[ADDR_W-1:2], 2'b00}
                             : {req_addr_i[ADDR_W-1:2], 2'b00};
    assign hsize_o  = WORD;
    assign hwrite_o = ap_rmw | (req_op_i == SW);   // RMW starts with a read

    assign wdata_al = req_wdata_i << {req_addr_i[1:0], 3'b000};   // Move to byte lane

    // Write path
    assign hwdata_o = dp_wdata;
    secded_encode i_wr_enc (
        .data_i  (dp_wdata),
        .check_o (hwcheck_o)
    );

    // Read path syndrome
    secded_encode i_rd_enc (
        .data_i  (hrdata_i),
        .check_o (rd_check)
    );
    assign rd_syn = rd_check ^ hrcheck_i;

    // Correction one cycle after the read, used by loads and by the RMW merge
    secded_decode i_dec (
        .data_i     (ld_data),
        .syndrome_i (ld_syn),
        .data_o     (fix_data),
        .ce_o       (fix_ce),
        .uce_o      (fix_uce)
    );

    // New lanes over the corrected old word
    always_comb begin
        case (dp_op)
            SB:      lane_mask = 4'b0001 << dp_addr[1:0];
            SH:      lane_mask = 4'b0011 << dp_addr[1:0];
            default: lane_mask = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = lane_mask[b] ? dp_wdata[8*b +: 8] : fix_data[8*b +: 8];
        end
    end

    always_comb begin
        rmw_d = rmw_q;
        case (rmw_q)
            RMW_IDLE: begin
                if (ap_req && req_sub) begin
                    rmw_d = RMW_READ;
                end
            end
            RMW_READ: begin
                if (dp_done) begin
                    rmw_d = hresp_i ? RMW_IDLE : RMW_WRITE;   // Bus error aborts
                end
            end
            RMW_WRITE: begin
                if (dp_done) begin
                    rmw_d = RMW_IDLE;
                end
            end
            default: rmw_d = RMW_IDLE;
        endcase
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rmw_q     <= RMW_IDLE;
            dp_valid  <= 1'b0;
            dp_write  <= 1'b0;
            rs_valid  <= 1'b0;
            rs_buserr <= 1'b0;
            ld_syn    <= '0;
        end else begin
            rmw_q <= rmw_d;
            if (hready_i) begin
                dp_valid <= ap_req | ap_rmw;   // Next data phase
                dp_write <= hwrite_o;
            end
            // Successful RMW read is internal and gets no response
            rs_valid <= dp_done & ~((rmw_q == RMW_READ) & ~hresp_i);
            if (dp_done) begin
                rs_buserr <= hresp_i;
                if (!dp_write) begin
                    ld_syn <= hresp_i ? '0 : rd_syn;
                end else if (rmw_q == RMW_IDLE) begin
                    ld_syn <= '0;   // Word store reports clean
                end
                // RMW write keeps the read syndrome for its response
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (ap_req) begin
            dp_op    <= req_op_i;
            dp_addr  <= req_addr_i;
            dp_wdata <= wdata_al;
        end else if (ap_rmw && hready_i) begin
            dp_wdata <= merged;
        end
        if (dp_done && !dp_write) begin
            ld_data <= hrdata_i;
        end
        if (dp_done) begin
            rs_op  <= dp_op;
            rs_off <= dp_addr[1:0];
        end
    end

    // Load extraction with sign or zero extension
    always_comb begin
        lane_data = fix_data >> {rs_off, 3'b000};
        case (rs_op)
            LB:      rsp_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
            LBU:     rsp_data_o = {24'b0, lane_data[7:0]};
            LH:      rsp_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
            LHU:     rsp_data_o = {16'b0, lane_data[15:0]};
            LW:      rsp_data_o = fix_data;
            default: rsp_data_o = '0;   // Stores
        endcase
        if (rs_buserr) begin
            rsp_data_o = '0;
        end
    end

    assign rsp_valid_o             = rs_valid;
    assign rsp_buserr_o            = rs_buserr;
    assign rsp_einfo_o[EINFO_ERR]  = |ld_syn;
    assign rsp_einfo_o[EINFO_CE]   = fix_ce;
    assign rsp_einfo_o[EINFO_UCE]  = fix_uce;

endmodule

//--- design/lsu_pkg.sv
////////////////////
// Core-side operation codes and LSU control encodings
// Op code has store in bit 3 and unsigned in bit 2 with the size in bits 1:0
////////////////////
package lsu_pkg;

    // Core operation
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    // Read-modify-write sequence for sub-word stores
    typedef enum logic [1:0] {
        RMW_IDLE  = 2'b00,
        RMW_READ  = 2'b01,  // Aligned word read in flight
        RMW_WRITE = 2'b10   // Merged word going back
    } lsu_rmw_e;

    localparam int OP_STORE_BIT = 3;    // Set for SB, SH and SW

    // Error info returned with every response
    localparam int LSU_EINFO_W = 3;
    localparam int EINFO_ERR   = 0;     // Nonzero syndrome
    localparam int EINFO_CE    = 1;     // Corrected
    localparam int EINFO_UCE   = 2;     // Uncorrectable

endpackage

//--- design/lsu_subsys_top.sv
////////////////////
// LSU with its ECC data RAM
// Byte addresses have one spare bit above the RAM for error testing
////////////////////
`timescale 1ns/1ps

module lsu_subsys_top #(
    parameter  int RAM_WORDS = 256,
    localparam int ADDR_W    = ahb_pkg::haddr_w(RAM_WORDS)
) (
    input  logic                            s_clk_i,
    input  logic                            arst_n_i,
    input  logic                            req_valid_i,
    input  lsu_pkg::lsu_op_e                req_op_i,
    input  logic [ADDR_W-1:0]               req_addr_i,
    input  logic [ahb_pkg::DATA_W-1:0]      req_wdata_i,
    output logic                            req_ready_o,
    output logic                            rsp_valid_o,
    output logic [ahb_pkg::DATA_W-1:0]      rsp_data_o,
    output logic [lsu_pkg::LSU_EINFO_W-1:0] rsp_einfo_o,
    output logic                            rsp_buserr_o,
    input  logic [ahb_pkg::CODE_W-1:0]      inj_mask_i   // Radiation test hook
);
    import ahb_pkg::*;

    logic [ADDR_W-1:0] haddr;
    htrans_e           htrans;
    hsize_e            hsize;
    logic              hwrite;
    logic [DATA_W-1:0] hwdata;
    logic [ECC_W-1:0]  hwcheck;
    logic [DATA_W-1:0] hrdata;
    logic [ECC_W-1:0]  hrcheck;
    logic              hready;
    logic              hresp;

    lsu #(
        .RAM_WORDS (RAM_WORDS)
    ) i_lsu (
        .s_clk_i      (s_clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_op_i     (req_op_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_data_o   (rsp_data_o),
        .rsp_einfo_o  (rsp_einfo_o),
        .rsp_buserr_o (rsp_buserr_o),
        .haddr_o      (haddr),
        .htrans_o     (htrans),
        .hsize_o      (hsize),
        .hwrite_o     (hwrite),
        .hwdata_o     (hwdata),
        .hwcheck_o    (hwcheck),
        .hrdata_i     (hrdata),
        .hrcheck_i    (hrcheck),
        .hready_i     (hready),
        .hresp_i      (hresp)
    );

    ahb_ecc_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .haddr_i    (haddr),
        .htrans_i   (htrans),
        .hsize_i    (hsize),
        .hwrite_i   (hwrite),
        .hwdata_i   (hwdata),
        .hwcheck_i  (hwcheck),
        .hrdata_o   (hrdata),
        .hrcheck_o  (hrcheck),
        .hready_o   (hready),
        .hresp_o    (hresp),
        .inj_mask_i (inj_mask_i)
    );

endmodule

//--- design/secded_decode.sv
////////////////////
// Syndrome is encode(data) XOR stored check bits
// Corrects one flipped bit and flags double and unmapped errors as uncorrectable
////////////////////
`timescale 1ns/1ps

module secded_decode (
    input  logic [ahb_pkg::DATA_W-1:0] data_i,      // Raw data as read
    input  logic [ahb_pkg::ECC_W-1:0]  syndrome_i,  // From the read path
    output logic [ahb_pkg::DATA_W-1:0] data_o,      // Corrected data
    output logic                       ce_o,        // Single error fixed
    output logic                       uce_o        // Beyond correction
);
    import ahb_pkg::*;

    logic [HAM_W-1:0]  ham;         // Position of the flipped bit
    logic              odd;         // Odd number of flipped bits
    logic              hit;         // Position is a data bit
    logic              chk_only;    // Position is a check bit or the parity bit
    logic [DATA_W-1:0] flip;        // One-hot correction mask

    assign ham = syndrome_i[HAM_W-1:0];

    // Parity bit syndrome already folds in bits 5:0 so the XOR of all is the codeword parity
    assign odd = ^syndrome_i;

    always_comb begin
        flip = '0;
        for (int d = 0; d < DATA_W; d++) begin
            flip[d] = (secded_pos(d) == ham);
        end
    end

    assign hit      = |flip;
    assign chk_only = ~|(ham & (ham - 1'b1));   // Zero or a power of two

    assign ce_o   = odd & (hit | chk_only);
    assign uce_o  = (syndrome_i != '0) & ~ce_o;   // Even parity or position past 38
    assign data_o = (odd & hit) ? (data_i ^ flip) : data_i;

endmodule

//--- design/secded_encode.sv
////////////////////
// Hamming(39,32) check bits from a data word
// Bit 6 is even parity over the data and check bits 5:0
////////////////////
`timescale 1ns/1ps

module secded_encode (
    input  logic [ahb_pkg::DATA_W-1:0] data_i,     // Word to protect
    output logic [ahb_pkg::ECC_W-1:0]  check_o     // Check bits
);
    import ahb_pkg::*;

    logic [HAM_W-1:0] ham;     // Hamming part

    // Each data bit folds its position into the check bits
    always_comb begin
        ham = '0;
        for (int d = 0; d < DATA_W; d++) begin
            if (data_i[d]) begin
                ham = ham ^ secded_pos(d);
            end
        end
    end

    // Overall parity makes double errors visible
    assign check_o = {(^data_i) ^ (^ham), ham};

endmodule

//--- test/tb_lsu_tasks.svh
////////////////////
// Request drivers and reference model for tb_lsu_top
// Uses the shadow words, fault counts and expected-response queue of the includer
////////////////////
`ifndef TB_LSU_TASKS_SVH
`define TB_LSU_TASKS_SVH

// Xorshift32 stream
function automatic logic [31:0] rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic int rand_word();
    return int'(rand_next() % 32'(WORDS));
endfunction

function automatic logic [ADDR_W-1:0] word_addr(input int w, input int off);
    return ADDR_W'(4 * w + off);
endfunction

// Store lanes start at the addressed byte, halfword lanes past byte 3 fall off the word
function automatic logic [31:0] merge_lanes(input logic [31:0] old, input lsu_op_e op,
                                            input int off, input logic [31:0] wdata);
    logic [31:0] res;
    int          span;
    res  = old;
    span = (op == SB) ? 1 : (op == SH) ? 2 : 4;
    for (int b = 0; b < span; b++) begin
        if (off + b < 4) begin
            res[8*(off+b) +: 8] = wdata[8*b +: 8];
        end
    end
    return res;
endfunction

// Addressed byte or half of the aligned word, sign or zero extended
function automatic logic [31:0] load_value(input logic [31:0] word, input lsu_op_e op,
                                           input int off);
    logic [31:0] lane;
    lane = word >> (8 * off);
    case (op)
        LB:      return {{24{lane[7]}}, lane[7:0]};
        LBU:     return {24'b0, lane[7:0]};
        LH:      return {{16{lane[15]}}, lane[15:0]};
        LHU:     return {16'b0, lane[15:0]};
        default: return word;
    endcase
endfunction

// Flipped bits in the stored codeword to error info {uce, ce, err}
function automatic logic [LSU_EINFO_W-1:0] einfo_of(input int nflips);
    case (nflips)
        0:       return 3'b000;
        1:       return 3'b011;   // Corrected
        default: return 3'b101;   // Uncorrectable
    endcase
endfunction

// Drive one request and hold it until the DUT takes it
task automatic issue_req(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [31:0] wdata, input rsp_t exp);
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    exp_q.push_back(exp);
    while (!req_ready) @(negedge clk);   // Ready is stable until the next rising edge
    issued++;
    if (op == SB || op == SH) begin
        @(negedge clk);
        req_valid = 1'b0;
        assert (!req_ready)
            else stop_failed("Ready stayed high after a sub-word store was accepted");
    end
endtask

task automatic store_op(input lsu_op_e op, input logic [ADDR_W-1:0] addr,
                        input logic [31:0] wdata);
    rsp_t exp;
    int   w;
    int   off;
    w   = int'(addr[ADDR_W-1:2]);
    off = int'(addr[1:0]);
    exp = '0;
    exp.care = 1'b1;   // Stores answer with zero data
    if (addr >= word_addr(WORDS, 0)) begin
        exp.buserr = 1'b1;   // Nothing written
    end else begin
        if (op != SW) begin
            exp.einfo = einfo_of(faults[w]);   // RMW read result
        end
        shadow[w] = merge_lanes(shadow[w], op, off, wdata);
        faults[w] = 0;
    end
    issue_req(op, addr, wdata, exp);
endtask

task automatic load_op(input lsu_op_e op, input logic [ADDR_W-1:0] addr);
    rsp_t exp;
    int   w;
    w   = int'(addr[ADDR_W-1:2]);
    exp = '0;
    exp.care = 1'b1;
    if (addr >= word_addr(WORDS, 0)) begin
        exp.buserr = 1'b1;
    end else begin
        exp.data  = load_value(shadow[w], op, int'(addr[1:0]));
        exp.einfo = einfo_of(faults[w]);
        exp.care  = (faults[w] < 2);   // Uncorrectable data is not defined
    end
    issue_req(op, addr, 32'd0, exp);
endtask

// Drop valid and wait for every outstanding response
task automatic finish_traffic();
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
endtask

// Word store with one or two distinct data bits flipped in the stored codeword
task automatic faulty_store(input int w, input logic [31:0] data, input int nflips);
    logic [CODE_W-1:0] mask;
    int                b0;
    int                b1;
    finish_traffic();
    b0   = int'(rand_next() % 32'd32);
    b1   = (b0 + 1 + int'(rand_next() % 32'd31)) % 32;
    mask = CODE_W'(1) << b0;
    if (nflips == 2) begin
        mask = mask | (CODE_W'(1) << b1);
    end
    inj_mask = mask;
    store_op(SW, word_addr(w, 0), data);
    finish_traffic();
    inj_mask  = '0;
    faults[w] = nflips;
endtask

`endif

//--- test/tb_lsu_top.sv
////////////////////
// LSU subsystem testbench with a 64-word RAM
// Responses are checked in request order against a shadow memory
////////////////////
`timescale 1ns/1ps

module tb_lsu_top;
    import lsu_pkg::*;
    import ahb_pkg::*;

    localparam int WORDS       = 64;
    localparam int ADDR_W      = haddr_w(WORDS);
    localparam int CYC_PER_REQ = 40;     // Cycle budget per issued request

    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [LSU_EINFO_W-1:0] einfo;
        logic                   buserr;
        logic                   care;    // Compare data
    } rsp_t;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   req_valid;
    lsu_op_e                req_op;
    logic [ADDR_W-1:0]      req_addr;
    logic [DATA_W-1:0]      req_wdata;
    logic                   req_ready;
    logic                   rsp_valid;
    logic [DATA_W-1:0]      rsp_data;
    logic [LSU_EINFO_W-1:0] rsp_einfo;
    logic                   rsp_buserr;
    logic [CODE_W-1:0]      inj_mask;

    logic [31:0] shadow [WORDS];    // Expected RAM contents
    int          faults [WORDS];    // Flipped bits still stored per word
    rsp_t        exp_q [$];
    logic [31:0] rng_state = 32'd75;
    int          issued    = 0;
    int          cycles    = 0;

    lsu_subsys_top #(
        .RAM_WORDS (WORDS)
    ) i_dut (
        .s_clk_i      (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_op_i     (req_op),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_ready_o  (req_ready),
        .rsp_valid_o  (rsp_valid),
        .rsp_data_o   (rsp_data),
        .rsp_einfo_o  (rsp_einfo),
        .rsp_buserr_o (rsp_buserr),
        .inj_mask_i   (inj_mask)
    );

    task automatic stop_failed(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    `include "tb_lsu_tasks.svh"

    initial begin
        forever #20 clk = ~clk;
    end

    // Hang guard with a budget that grows with each accepted request
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYC_PER_REQ * (issued + 1)) begin
            stop_failed($sformatf("Timeout: no progress for too long after %0d cycles", cycles));
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        rsp_t head;
        if (arst_n && rsp_valid) begin
            assert (exp_q.size() != 0)
                else stop_failed("A response arrived with no request outstanding");
            head = exp_q.pop_front();
            assert (rsp_buserr == head.buserr)
                else stop_failed($sformatf("ERROR %0t: bus error %b, expected %b",
                                           $time, rsp_buserr, head.buserr));
            assert (rsp_einfo == head.einfo)
                else stop_failed($sformatf("ERROR %0t: einfo %b, expected %b",
                                           $time, rsp_einfo, head.einfo));
            assert (!head.care || rsp_data == head.data)
                else stop_failed($sformatf("ERROR %0t: data %h, expected %h",
                                           $time, rsp_data, head.data));
        end
    end

    initial begin
        int          w;
        logic [31:0] d;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_op    = LW;
        req_addr  = '0;
        req_wdata = '0;
        inj_mask  = '0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;
            faults[i] = 0;
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (req_ready && !rsp_valid && i_dut.htrans == IDLE)
            else stop_failed("DUT is not idle and ready after reset");

        // Fill every word, then read back back-to-back
        for (int i = 0; i < WORDS; i++) begin
            store_op(SW, word_addr(i, 0), rand_next());
        end
        for (int i = 0; i < WORDS; i++) begin
            load_op(LW, word_addr(i, 0));
        end
        finish_traffic();

        // Sub-word stores at each offset and lane extraction
        for (int off = 0; off < 4; off++) begin
            w = rand_word();
            store_op(SB, word_addr(w, off), rand_next());
            load_op(LW, word_addr(w, 0));
            w = rand_word();
            store_op(SH, word_addr(w, off), rand_next());
            load_op(LW, word_addr(w, 0));
            load_op(LB, word_addr(w, off));
            load_op(LBU, word_addr(w, off));
        end
        for (int off = 0; off < 4; off += 2) begin
            w = rand_word();
            load_op(LH, word_addr(w, off));
            load_op(LHU, word_addr(w, off));
        end
        finish_traffic();

        // Single flip is corrected and an RMW over it writes the clean merge
        w = rand_word();
        d = rand_next();
        faulty_store(w, d, 1);
        load_op(LW, word_addr(w, 0));
        load_op(LH, word_addr(w, 2));
        store_op(SB, word_addr(w, 1), rand_next());
        load_op(LW, word_addr(w, 0));
        finish_traffic();

        // Double flip
        w = rand_word();
        faulty_store(w, rand_next(), 2);
        load_op(LW, word_addr(w, 0));
        store_op(SW, word_addr(w, 0), rand_next());   // Rewrite clears it
        load_op(LW, word_addr(w, 0));
        finish_traffic();

        // Out-of-range accesses leave the aliased in-range word unchanged
        for (int i = 0; i < 4; i++) begin
            w = WORDS + rand_word();
            load_op(LW, word_addr(w, 0));
            store_op(SW, word_addr(w, 0), rand_next());
            load_op(LW, word_addr(w - WORDS, 0));
            store_op(SB, word_addr(w, i), rand_next());
            store_op(SH, word_addr(w, i), rand_next());
            load_op(LW, word_addr(w - WORDS, 0));
        end
        finish_traffic();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
design/ahb_pkg.sv
design/lsu_pkg.sv
design/secded_encode.sv
design/secded_decode.sv
design/lsu.sv
design/ahb_ecc_ram.sv
design/lsu_subsys_top.sv
test/tb_lsu_top.sv
